// File: source/alu_cfg.svh
////////////////////////////////////////////////////////////
// Width settings for the execute block, included by the
// package and by any module that sizes logic from them
////////////////////////////////////////////////////////////
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Data path width, operands and result
`define WORD_W 16

// Opcode field width
`define OPER_W 4

`define CLA_GROUP 4 // Bits per lookahead group

`endif

// File: source/aluPkg.sv
////////////////////////////////////////////////////////////
// Shared types for the ALU and execute stage, referenced
// with aluPkg:: scoped names
////////////////////////////////////////////////////////////
`include "alu_cfg.svh"

package aluPkg;

    typedef logic [`WORD_W-1:0] word_t; // One data word
    typedef logic [$clog2(`WORD_W)-1:0] shamt_t; // Shift amount, 0 to 15

    // ALU opcodes, 1011 has no entry
    typedef enum logic [`OPER_W-1:0] {
        opRol  = 4'b0000,
        opSll  = 4'b0001,
        opRor  = 4'b0010,
        opSrl  = 4'b0011,
        opAdd  = 4'b0100,
        opSub  = 4'b0101, // B minus A
        opXor  = 4'b0110,
        opAndn = 4'b0111, // A and not B
        opSeq  = 4'b1000,
        opSlt  = 4'b1001,
        opSle  = 4'b1010,
        opSco  = 4'b1100, // Carry of A plus B
        opLbi  = 4'b1101,
        opBtr  = 4'b1110,
        opSlbi = 4'b1111
    } aluOp_e;

    // Shifter ops, same order as low opcode bits
    typedef enum logic [1:0] {
        shRol = 2'b00,
        shSll = 2'b01,
        shRor = 2'b10,
        shSrl = 2'b11
    } shiftOp_e;

    typedef struct packed {
        logic zf; // Result is zero
        logic sf; // Result MSB
        logic of; // Signed overflow
        logic cf; // Adder carry out
    } aluFlags_t;

endpackage

// File: source/barrelShifter.sv
////////////////////////////////////////////////////////////
// Logarithmic shifter for rotates and logical shifts,
// used combinationally inside the ALU
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "alu_cfg.svh"

module barrelShifter (
    input  aluPkg::word_t    in,    // Value to shift
    input  aluPkg::shamt_t   shamt, // Bit count
    input  aluPkg::shiftOp_e oper,  // Rotate or shift, left or right
    output aluPkg::word_t    out
);

    localparam int W    = `WORD_W;
    localparam int SH_W = $bits(aluPkg::shamt_t); // One stage per amount bit

    aluPkg::word_t stage [0:SH_W]; // stage[k] is input to stage k

    assign stage[0] = in;

    for (genvar k = 0; k < SH_W; k++) begin : gStage
        localparam int N = 1 << k; // Stage moves by 1, 2, 4, 8

        aluPkg::word_t cur;
        aluPkg::word_t shifted;

        assign cur = stage[k];

        always_comb begin
            case (oper)
                aluPkg::shRol: shifted = {cur[W-1-N:0], cur[W-1 -: N]}; // Wrap top bits
                aluPkg::shSll: shifted = {cur[W-1-N:0], {N{1'b0}}};
                aluPkg::shRor: shifted = {cur[N-1:0], cur[W-1:N]}; // Wrap low bits
                default:       shifted = {{N{1'b0}}, cur[W-1:N]}; // Logical right
            endcase
        end

        // Bypass when this amount bit is clear
        assign stage[k+1] = shamt[k] ? shifted : cur;
    end

    assign out = stage[SH_W];

endmodule

// File: source/claAdder.sv
////////////////////////////////////////////////////////////
// Two level carry lookahead adder, groups of CLA_GROUP bits
// chained at group level; carry into MSB kept for overflow
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "alu_cfg.svh"

module claAdder (
    input  aluPkg::word_t a,
    input  aluPkg::word_t b,
    input  logic          cIn,
    output aluPkg::word_t sum,
    output logic          cOut, // Carry out of the top bit
    output logic          cMsb  // Carry into the top bit
);

    localparam int W    = `WORD_W;
    localparam int G    = `CLA_GROUP;
    localparam int NGRP = W / G;

    aluPkg::word_t   p;     // Bit propagate
    aluPkg::word_t   g;     // Bit generate
    logic [W:0]      carry; // Carry into each bit, plus carry out
    logic [NGRP-1:0] grpG;  // Group generate
    logic [NGRP-1:0] grpP;  // Group propagate
    logic [NGRP:0]   grpC;  // Carry into each group

    // Sum of products carry into position n of a group
    function automatic logic lookahead(
        input logic [G-1:0] gv,
        input logic [G-1:0] pv,
        input logic         cin,
        input int           n
    );
        logic run;
        logic c;
        c   = 1'b0;
        run = 1'b1; // AND of propagates above current term
        for (int k = G - 1; k >= 0; k--) begin
            if (k < n) begin
                c   = c | (gv[k] & run);
                run = run & pv[k];
            end
        end
        return c | (run & cin);
    endfunction

    assign p = a ^ b;
    assign g = a & b;

    assign grpC[0] = cIn;

    for (genvar gi = 0; gi < NGRP; gi++) begin : gGroup
        localparam int LO = gi * G; // Low bit of this group

        logic [G-1:0] gp;
        logic [G-1:0] gg;

        assign gp = p[LO +: G];
        assign gg = g[LO +: G];

        // Group terms for the second level
        assign grpG[gi] = lookahead(gg, gp, 1'b0, G);
        assign grpP[gi] = &gp;

        // Second level, group carries chained
        assign grpC[gi+1] = grpG[gi] | (grpP[gi] & grpC[gi]);

        for (genvar j = 0; j < G; j++) begin : gBit
            assign carry[LO+j] = lookahead(gg, gp, grpC[gi], j); // j = 0 gives group cin
        end
    end

    assign carry[W] = grpC[NGRP];

    assign sum  = p ^ carry[W-1:0];
    assign cOut = carry[W];
    assign cMsb = carry[W-1];

endmodule

// File: source/alu.sv
////////////////////////////////////////////////////////////
// Combinational 16-bit ALU with shared adder and shifter,
// producing a result and zero, sign, overflow, carry flags
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "alu_cfg.svh"

module alu (
    input  aluPkg::word_t     inA,
    input  aluPkg::word_t     inB,
    input  aluPkg::aluOp_e    oper,
    output aluPkg::word_t     out,
    output aluPkg::aluFlags_t flags
);

    localparam int W = `WORD_W;

    logic             subLike;  // Adder computes B minus A
    logic             arithOp;  // Adder carries reach the flags
    logic             validOp;  // Opcode 1011 is not
    aluPkg::word_t    opA;      // Prepared A
    aluPkg::word_t    opB;      // Prepared B
    logic             cIn;
    aluPkg::shamt_t   shAmt;
    aluPkg::shiftOp_e shOp;
    aluPkg::word_t    shiftOut;
    aluPkg::word_t    sum;
    logic             cOut;
    logic             cMsb;
    logic             ovf;      // Signed overflow of opA plus opB
    logic             sumZero;
    logic             lessThan; // A < B signed
    aluPkg::word_t    bitRev;

    assign subLike = oper inside {aluPkg::opSub, aluPkg::opSeq, aluPkg::opSlt,
                                  aluPkg::opSle};
    assign arithOp = oper inside {aluPkg::opAdd, aluPkg::opSub, aluPkg::opSco};
    assign validOp = (oper != aluPkg::aluOp_e'(4'b1011));

    // Two's complement of A for B minus A
    assign opA = subLike ? ~inA : inA;
    assign cIn = subLike;

    always_comb begin
        case (oper)
            aluPkg::opAndn: opB = ~inB;
            aluPkg::opLbi:  opB = '0;
            default:        opB = inB;
        endcase
    end

    // SLBI forces a left shift by half a word
    assign shAmt = (oper == aluPkg::opSlbi) ? aluPkg::shamt_t'(W / 2) : inB[3:0];
    assign shOp  = (oper == aluPkg::opSlbi) ? aluPkg::shSll
                                            : aluPkg::shiftOp_e'(oper[1:0]);

    barrelShifter uShift (
        .in    (opA),
        .shamt (shAmt),
        .oper  (shOp),
        .out   (shiftOut)
    );

    claAdder uAdd (
        .a    (opA),
        .b    (opB),
        .cIn  (cIn),
        .sum  (sum),
        .cOut (cOut),
        .cMsb (cMsb)
    );

    assign ovf     = cOut ^ cMsb; // Carry in and out of MSB differ
    assign sumZero = (sum == '0);

    // B minus A positive, sign corrected by overflow
    assign lessThan = ~(sum[W-1] ^ ovf) & ~sumZero;

    always_comb begin
        for (int i = 0; i < W; i++) begin
            bitRev[i] = inA[W-1-i];
        end
    end

    always_comb begin
        case (oper)
            aluPkg::opRol,
            aluPkg::opSll,
            aluPkg::opRor,
            aluPkg::opSrl:  out = shiftOut;
            aluPkg::opAdd,
            aluPkg::opSub:  out = sum;
            aluPkg::opXor:  out = opA ^ opB;
            aluPkg::opAndn: out = opA & opB; // opB already inverted
            aluPkg::opSeq:  out = aluPkg::word_t'(sumZero);
            aluPkg::opSlt:  out = aluPkg::word_t'(lessThan);
            aluPkg::opSle:  out = aluPkg::word_t'(lessThan | sumZero);
            aluPkg::opSco:  out = aluPkg::word_t'(cOut);
            aluPkg::opLbi:  out = inB; // Immediate passes through
            aluPkg::opBtr:  out = bitRev;
            aluPkg::opSlbi: out = shiftOut | inB;
            default:        out = '0;
        endcase
    end

    // Unused opcode reports no flags at all
    assign flags.zf = validOp & (out == '0);
    assign flags.sf = validOp & out[W-1];
    assign flags.of = arithOp & ovf;
    assign flags.cf = arithOp & cOut;

endmodule

// File: source/aluStage.sv
////////////////////////////////////////////////////////////
// Registered execute stage around the ALU; start captures
// an operation, result, flags and done follow one edge later
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module aluStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,  // One cycle strobe per operation
    input  aluPkg::aluOp_e    opIn,
    input  aluPkg::word_t     inA,
    input  aluPkg::word_t     inB,
    output aluPkg::word_t     result,
    output aluPkg::aluFlags_t flags,
    output logic              done    // Pulses with each new result
);

    aluPkg::aluOp_e    opReg;   // Captured operation
    aluPkg::word_t     aReg;
    aluPkg::word_t     bReg;
    logic              busy;    // Captured operands are valid
    aluPkg::word_t     aluOut;
    aluPkg::aluFlags_t aluFlags;

    // Operand capture on start
    always_ff @(posedge clk) begin
        if (start) begin
            opReg <= opIn;
            aReg  <= inA;
            bReg  <= inB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= start; // New start every cycle allowed
        end
    end

    alu uAlu (
        .inA   (aReg),
        .inB   (bReg),
        .oper  (opReg),
        .out   (aluOut),
        .flags (aluFlags)
    );

    // Output register holds until the next operation
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= busy;
            if (busy) begin
                result <= aluOut;
                flags  <= aluFlags;
            end
        end
    end

endmodule

// File: bench/aluStageTb.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the execute stage; replays
// golden vectors with random idle gaps, run from project root
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "alu_cfg.svh"

module aluStageTb;

    localparam int    CLK_PERIOD = 4;
    localparam int    RST_CYCLES = 8;
    localparam int    BURST      = 16; // Last vectors go back to back
    localparam int    DONE_DELAY = 3;  // Edges from drive to monitor sample
    localparam string GOLDEN     = "bench/alu_golden.txt";

    logic              clk;
    logic              rst;
    logic              start;
    aluPkg::aluOp_e    opIn;
    aluPkg::word_t     inA;
    aluPkg::word_t     inB;
    aluPkg::word_t     result;
    aluPkg::aluFlags_t flags;
    logic              done;

    // Golden vector fields by line
    logic [`OPER_W-1:0] vecOp  [$];
    aluPkg::word_t      vecA   [$];
    aluPkg::word_t      vecB   [$];
    aluPkg::word_t      vecRes [$];
    logic [3:0]         vecFlg [$];

    int pendIdx [$]; // Vector index per start in flight
    int pendCyc [$]; // Cycle count at its drive edge

    int                cycleCnt;
    int                errCount;
    int                checkCount;
    int                doneCount;
    logic              loaded;
    logic [15:0]       lfsr;
    aluPkg::word_t     lastRes; // Expected held value
    logic [3:0]        lastFlg;

    aluStage dut_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .opIn   (opIn),
        .inA    (inA),
        .inB    (inB),
        .result (result),
        .flags  (flags),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1; // Readers see the old count

    // Galois LFSR step with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[0];
        s  = s >> 1;
        if (fb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    // Idle gap of 0 to 3 cycles from two LFSR bits
    task automatic pickGap(output int gap);
        logic [1:0] bits;
        for (int k = 0; k < 2; k++) begin
            lfsr    = lfsrNext(lfsr);
            bits[k] = lfsr[0];
        end
        gap = int'(bits);
    endtask

    task automatic checkValue(input string name, input int idx,
                              input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Error: %s at vector %0d got 0x%h expected 0x%h at %0t ns",
                     name, idx, got, exp, $time);
        end
    endtask

    // Comment and blank lines fail the scan and are skipped
    task automatic loadGolden();
        int            fd;
        int            code;
        string         line;
        logic [3:0]    op;
        aluPkg::word_t a;
        aluPkg::word_t b;
        aluPkg::word_t r;
        logic [3:0]    f;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            errCount++;
            $display("Could not open the vector file %s", GOLDEN);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%h %h %h %h %h", op, a, b, r, f);
                    if (code == 5) begin
                        vecOp.push_back(op);
                        vecA.push_back(a);
                        vecB.push_back(b);
                        vecRes.push_back(r);
                        vecFlg.push_back(f);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Response monitor sampling flop outputs on the rising edge
    always @(posedge clk) begin
        int idx;
        int cyc;
        if (!rst && loaded) begin
            if (done) begin
                doneCount++;
                if (pendIdx.size() == 0) begin
                    errCount++;
                    $display("done pulsed at %0t ns with no operation outstanding", $time);
                end else begin
                    idx = pendIdx.pop_front();
                    cyc = pendCyc.pop_front();
                    checkValue("result", idx, 32'(result), 32'(vecRes[idx]));
                    checkValue("flags", idx, 32'(flags), 32'(vecFlg[idx]));
                    checkValue("done latency", idx, 32'(cycleCnt - cyc), 32'(DONE_DELAY));
                    lastRes = vecRes[idx];
                    lastFlg = vecFlg[idx];
                end
            end else begin
                checkValue("held result", -1, 32'(result), 32'(lastRes)); // Idle cycle
                checkValue("held flags", -1, 32'(flags), 32'(lastFlg));
            end
        end
    end

    // Watchdog sized from the vector count once loaded
    initial begin
        wait (loaded === 1'b1);
        #(vecOp.size() * 6 * CLK_PERIOD + 200);
        $display("Watchdog expired before all operations completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int gap;
        int nVec;
        int waitCnt;
        cycleCnt   = 0;
        errCount   = 0;
        checkCount = 0;
        doneCount  = 0;
        loaded     = 1'b0;
        lastRes    = '0;
        lastFlg    = '0;
        lfsr       = 16'd61541;
        rst        = 1'b1;
        start      = 1'b0;
        opIn       = aluPkg::opAdd;
        inA        = '0;
        inB        = '0;

        loadGolden();
        nVec   = vecOp.size();
        loaded = 1'b1;
        if (nVec == 0) begin
            errCount++;
            $display("No vectors were read from %s", GOLDEN);
        end

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkValue("done", -1, 32'(done), 32'd0); // Reset values before any start
        checkValue("result", -1, 32'(result), 32'd0);
        checkValue("flags", -1, 32'(flags), 32'd0);

        for (int i = 0; i < nVec; i++) begin
            if (i < nVec - BURST) begin
                pickGap(gap);
            end else begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                start <= 1'b0;
            end
            @(posedge clk);
            start <= 1'b1;
            opIn  <= aluPkg::aluOp_e'(vecOp[i]);
            inA   <= vecA[i];
            inB   <= vecB[i];
            pendIdx.push_back(i);
            pendCyc.push_back(cycleCnt);
        end
        @(posedge clk);
        start <= 1'b0;

        // Drain what is still in flight
        waitCnt = 0;
        while (pendIdx.size() != 0 && waitCnt < 2 * DONE_DELAY) begin
            @(posedge clk);
            waitCnt++;
        end
        repeat (2) @(posedge clk); // Room for a stray done
        @(negedge clk); // Monitor has finished the last edge

        if (pendIdx.size() != 0) begin
            errCount++;
            $display("%0d operations never produced done", pendIdx.size());
        end
        if (doneCount != nVec) begin
            errCount++;
            $display("done pulsed %0d times for %0d operations", doneCount, nVec);
        end

        $display("Vectors: %0d, checks: %0d, errors: %0d", nVec, checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bench/alu_golden.txt
// opcode A B result flags, all hex; flags bits are zf sf of cf
// sub and compares work on B minus A, shift amount is B[3:0]
0 8000 0000 8000 4
0 8000 0001 0001 0
0 0001 000f 8000 4
0 1234 0004 2341 0
0 abcd fff7 e6d5 4
1 0001 000f 8000 4
1 8000 0001 0000 8
1 ffff 0004 fff0 4
1 00ff 0009 fe00 4
2 0001 0001 8000 4
2 8000 000f 0001 0
2 abcd 0008 cdab 4
2 f00f 0006 3fc0 0
3 8000 0001 4000 0
3 8000 000f 0001 0
3 0001 0001 0000 8
3 abcd 0003 1579 0
f 0012 0034 1234 0
f 8000 0001 0001 0
f 0080 0000 8000 4
f 00ab ff00 ff00 4
4 0001 0002 0003 0
4 7fff 0001 8000 6
4 ffff 0001 0000 9
4 8000 ffff 7fff 3
4 8000 8000 0000 b
4 ffff ffff fffe 5
4 7fff 7fff fffe 6
5 0001 0003 0002 1
5 0003 0001 fffe 4
5 0005 0005 0000 9
5 0001 8000 7fff 3
5 8000 0000 8000 6
5 ffff 0001 0002 0
5 7fff 8000 0001 3
c ffff 0001 0001 1
c 7fff 0001 0000 a
c 8000 8000 0001 3
c 1234 1111 0000 8
8 1234 1234 0001 0
8 1234 1235 0000 8
8 8000 7fff 0000 8
9 0001 0002 0001 0
9 0002 0001 0000 8
9 0005 0005 0000 8
9 8000 7fff 0001 0
9 7fff 8000 0000 8
9 8000 0000 0001 0
9 0001 8000 0000 8
a 0005 0005 0001 0
a 0006 0005 0000 8
a 8000 7fff 0001 0
a 7fff 8000 0000 8
a fffe ffff 0001 0
6 ffff 0f0f f0f0 4
6 aaaa 5555 ffff 4
7 ffff 0f0f f0f0 4
7 1234 ffff 0000 8
d 1234 8000 8000 4
d ffff 0000 0000 8
e 0001 0000 8000 4
e 1234 0000 2c48 0
b ffff ffff 0000 0
b 0000 0000 0000 0

// File: src.f
+incdir+source
source/aluPkg.sv
source/barrelShifter.sv
source/claAdder.sv
source/alu.sv
source/aluStage.sv
bench/aluStageTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module aluStageTb \
    --Mdir "$BUILD_DIR" -o aluStageTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/aluStageTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
